/* axis_pkg.sv */
package axis_pkg;

    // ========================================
    // Stream beat geometry
    // ========================================

    // Bytes carried per beat with one tkeep bit each
    localparam int data_bytes = 8;

    // Width of tdata
    localparam int data_bits = data_bytes * 8;

    // ========================================
    // Statistics
    // ========================================

    // Delivered and dropped packet counters
    localparam int cnt_bits = 16;

endpackage

/* pkt_fifo_pkg.sv */
package pkt_fifo_pkg;

    // ========================================
    // Packet FIFO storage
    // ========================================

    // Words held by the FIFO memory
    localparam int fifo_depth = 64;

    // Memory address width
    localparam int addr_bits = 6;

    // Pointer width with one extra bit to tell full from empty
    localparam int ptr_bits = addr_bits + 1;

endpackage

/* axis_full_pipe.sv */
`timescale 1ns/1ns

module axis_full_pipe (
    input  logic                            axis_out_if,
    input  logic                            arst_n,
    input  logic                            in_tvalid,
    input  logic [axis_pkg::data_bits-1:0]  in_tdata,
    input  logic [axis_pkg::data_bytes-1:0] in_tkeep,
    input  logic                            in_tlast,
    output logic                            in_tready,
    output logic                            out_tvalid,
    output logic [axis_pkg::data_bits-1:0]  out_tdata,
    output logic [axis_pkg::data_bytes-1:0] out_tkeep,
    output logic                            out_tlast,
    input  logic                            out_tready
);

    import axis_pkg::*;

    // Skid register occupied whenever in_tready is low
    logic [data_bits-1:0]  skid_tdata;
    logic [data_bytes-1:0] skid_tkeep;
    logic                  skid_tlast;

    logic main_free;
    logic load_from_in;
    logic load_skid;
    logic load_from_skid;

    // ========================================
    // Load decisions
    // ========================================

    // Main register can take a new word this cycle
    assign main_free = !out_tvalid || out_tready;

    // Skid empty and main free, so the input goes straight to main
    assign load_from_in = in_tready && main_free;

    // Word accepted while main is blocked
    assign load_skid = in_tvalid && in_tready && !main_free;

    // Skid drains into main once the output moves
    assign load_from_skid = !in_tready && out_tready;

    // ========================================
    // Control
    // ========================================

    always_ff @(posedge axis_out_if or negedge arst_n) begin
        if (!arst_n) begin
            out_tvalid <= 1'b0;
            in_tready  <= 1'b1;
        end else begin
            if (load_from_in) begin
                out_tvalid <= in_tvalid;
            end else if (load_from_skid) begin
                out_tvalid <= 1'b1;
                in_tready  <= 1'b1;
            end
            if (load_skid) begin
                in_tready <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge axis_out_if) begin
        if (load_from_in) begin
            out_tdata <= in_tdata;
            out_tkeep <= in_tkeep;
            out_tlast <= in_tlast;
        end else if (load_from_skid) begin
            out_tdata <= skid_tdata;
            out_tkeep <= skid_tkeep;
            out_tlast <= skid_tlast;
        end
        if (load_skid) begin
            skid_tdata <= in_tdata;
            skid_tkeep <= in_tkeep;
            skid_tlast <= in_tlast;
        end
    end

    // A stalled word stays put and stays valid
    a_hold_stable : assert property (
        @(posedge axis_out_if) disable iff (!arst_n)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
    );

endmodule

/* axis_pkt_fifo.sv */
`timescale 1ns/1ns

module axis_pkt_fifo (
    input  logic                            axis_out_if,
    input  logic                            arst_n,
    input  logic                            in_tvalid,
    input  logic [axis_pkg::data_bits-1:0]  in_tdata,
    input  logic [axis_pkg::data_bytes-1:0] in_tkeep,
    input  logic                            in_tlast,
    output logic                            out_tvalid,
    output logic [axis_pkg::data_bits-1:0]  out_tdata,
    output logic [axis_pkg::data_bytes-1:0] out_tkeep,
    output logic                            out_tlast,
    input  logic                            out_tready,
    output logic                            oflow
);

    import axis_pkg::*;
    import pkt_fifo_pkg::*;

    // One storage array per field
    logic [data_bits-1:0]  mem_tdata [fifo_depth];
    logic [data_bytes-1:0] mem_tkeep [fifo_depth];
    logic                  mem_tlast [fifo_depth];

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    // Start of the packet being written that moves with each kept tlast
    logic [ptr_bits-1:0] cmt_next;
    // Readable limit trailing cmt_next by one cycle
    logic [ptr_bits-1:0] cmt_ptr;

    logic [ptr_bits-1:0] used;
    logic                full;
    logic                drop;
    logic                wr_en;
    logic                discard;
    logic                drop_last;
    logic                rd_en;

    // ========================================
    // Write side
    // ========================================

    // Freed words count as soon as the prefetch register takes them
    assign used = wr_ptr - rd_ptr;
    assign full = (used == ptr_bits'(fifo_depth));

    // A packet longer than the memory always reaches full here
    assign discard   = in_tvalid && (drop || full);
    assign wr_en     = in_tvalid && !drop && !full;
    assign drop_last = discard && in_tlast;

    always_ff @(posedge axis_out_if or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            cmt_next <= '0;
            cmt_ptr  <= '0;
            drop     <= 1'b0;
            oflow    <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (in_tlast) begin
                    cmt_next <= wr_ptr + 1'b1;
                end
            end else if (in_tvalid && full && !drop) begin
                // First word that does not fit throws away the partial packet
                wr_ptr <= cmt_next;
            end

            if (discard) begin
                drop <= !in_tlast;
            end

            oflow   <= drop_last;
            cmt_ptr <= cmt_next;
        end
    end

    always_ff @(posedge axis_out_if) begin
        if (wr_en) begin
            mem_tdata[wr_ptr[addr_bits-1:0]] <= in_tdata;
            mem_tkeep[wr_ptr[addr_bits-1:0]] <= in_tkeep;
            mem_tlast[wr_ptr[addr_bits-1:0]] <= in_tlast;
        end
    end

    // ========================================
    // Read side
    // ========================================

    // Only whole packets are visible, so reads never run dry mid-packet
    assign rd_en = (rd_ptr != cmt_ptr) && (!out_tvalid || out_tready);

    always_ff @(posedge axis_out_if or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr     <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr     <= rd_ptr + 1'b1;
                out_tvalid <= 1'b1;
            end else if (out_tready) begin
                out_tvalid <= 1'b0;
            end
        end
    end

    // Prefetch register
    always_ff @(posedge axis_out_if) begin
        if (rd_en) begin
            out_tdata <= mem_tdata[rd_ptr[addr_bits-1:0]];
            out_tkeep <= mem_tkeep[rd_ptr[addr_bits-1:0]];
            out_tlast <= mem_tlast[rd_ptr[addr_bits-1:0]];
        end
    end

    // ========================================
    // Checks
    // ========================================

    // Read pointer never runs past the commit point
    a_rd_behind_cmt : assert property (
        @(posedge axis_out_if) disable iff (!arst_n)
        ptr_bits'(cmt_ptr - rd_ptr) <= ptr_bits'(fifo_depth)
    );

    // Overflow is a single-cycle pulse
    a_oflow_pulse : assert property (
        @(posedge axis_out_if) disable iff (!arst_n)
        oflow |=> !oflow
    );

endmodule

/* axis_pkt_counters.sv */
`timescale 1ns/1ns

module axis_pkt_counters (
    input  logic                          axis_out_if,
    input  logic                          arst_n,
    input  logic                          out_tvalid,
    input  logic                          out_tready,
    input  logic                          out_tlast,
    input  logic                          oflow,
    output logic [axis_pkg::cnt_bits-1:0] pkt_count,
    output logic [axis_pkg::cnt_bits-1:0] drop_count
);

    import axis_pkg::*;

    logic pkt_done;
    logic pkt_max;
    logic drop_max;

    // Last beat of a packet leaves the output port
    assign pkt_done = out_tvalid && out_tready && out_tlast;

    // Both counters stick at all ones
    assign pkt_max  = (pkt_count == {cnt_bits{1'b1}});
    assign drop_max = (drop_count == {cnt_bits{1'b1}});

    always_ff @(posedge axis_out_if or negedge arst_n) begin
        if (!arst_n) begin
            pkt_count  <= '0;
            drop_count <= '0;
        end else begin
            if (pkt_done && !pkt_max) begin
                pkt_count <= pkt_count + 1'b1;
            end
            if (oflow && !drop_max) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

/* axis_pkt_buffer.sv */
`timescale 1ns/1ns

module axis_pkt_buffer (
    input  logic                            axis_out_if,
    input  logic                            arst_n,
    input  logic                            in_tvalid,
    input  logic [axis_pkg::data_bits-1:0]  in_tdata,
    input  logic [axis_pkg::data_bytes-1:0] in_tkeep,
    input  logic                            in_tlast,
    output logic                            out_tvalid,
    output logic [axis_pkg::data_bits-1:0]  out_tdata,
    output logic [axis_pkg::data_bytes-1:0] out_tkeep,
    output logic                            out_tlast,
    input  logic                            out_tready,
    output logic                            oflow,
    output logic [axis_pkg::cnt_bits-1:0]   pkt_count,
    output logic [axis_pkg::cnt_bits-1:0]   drop_count
);

    import axis_pkg::*;

    // FIFO to pipe
    logic                  fifo_tvalid;
    logic [data_bits-1:0]  fifo_tdata;
    logic [data_bytes-1:0] fifo_tkeep;
    logic                  fifo_tlast;
    logic                  fifo_tready;

    axis_pkt_fifo u_fifo (
        .axis_out_if (axis_out_if),
        .arst_n      (arst_n),
        .in_tvalid   (in_tvalid),
        .in_tdata    (in_tdata),
        .in_tkeep    (in_tkeep),
        .in_tlast    (in_tlast),
        .out_tvalid  (fifo_tvalid),
        .out_tdata   (fifo_tdata),
        .out_tkeep   (fifo_tkeep),
        .out_tlast   (fifo_tlast),
        .out_tready  (fifo_tready),
        .oflow       (oflow)
    );

    // Output slice
    axis_full_pipe u_pipe (
        .axis_out_if (axis_out_if),
        .arst_n      (arst_n),
        .in_tvalid   (fifo_tvalid),
        .in_tdata    (fifo_tdata),
        .in_tkeep    (fifo_tkeep),
        .in_tlast    (fifo_tlast),
        .in_tready   (fifo_tready),
        .out_tvalid  (out_tvalid),
        .out_tdata   (out_tdata),
        .out_tkeep   (out_tkeep),
        .out_tlast   (out_tlast),
        .out_tready  (out_tready)
    );

    axis_pkt_counters u_counters (
        .axis_out_if (axis_out_if),
        .arst_n      (arst_n),
        .out_tvalid  (out_tvalid),
        .out_tready  (out_tready),
        .out_tlast   (out_tlast),
        .oflow       (oflow),
        .pkt_count   (pkt_count),
        .drop_count  (drop_count)
    );

endmodule

/* tb_axis_pkt_buffer.sv */
`timescale 1ns/1ns

module tb_axis_pkt_buffer;

    import axis_pkg::*;
    import pkt_fifo_pkg::*;

    // Words that leave the FIFO memory under back-pressure
    localparam int pipe_words     = 2;
    localparam int prefetch_words = 1;
    localparam int num_random     = 100;

    logic                  axis_out_if;
    logic                  arst_n;
    logic                  in_tvalid;
    logic [data_bits-1:0]  in_tdata;
    logic [data_bytes-1:0] in_tkeep;
    logic                  in_tlast;
    logic                  out_tvalid;
    logic [data_bits-1:0]  out_tdata;
    logic [data_bytes-1:0] out_tkeep;
    logic                  out_tlast;
    logic                  out_tready;
    logic                  oflow;
    logic [cnt_bits-1:0]   pkt_count;
    logic [cnt_bits-1:0]   drop_count;

    // One queue of expected output words per field
    logic [data_bits-1:0]  exp_data [$];
    logic [data_bytes-1:0] exp_keep [$];
    logic                  exp_last [$];

    logic [15:0] lfsr_state = 16'd42479;
    int          rand_len [num_random];
    int          kept_words;
    int          rcv_words;
    int          rcv_pkts;
    int          oflow_seen;
    int          exp_pkts;
    int          exp_drops;
    int          err_value;
    int          err_other;
    int          total_words;
    bit          in_pkt;
    bit          ready_random;
    bit          watchdog_armed;

    axis_pkt_buffer UUT (
        .axis_out_if (axis_out_if),
        .arst_n      (arst_n),
        .in_tvalid   (in_tvalid),
        .in_tdata    (in_tdata),
        .in_tkeep    (in_tkeep),
        .in_tlast    (in_tlast),
        .out_tvalid  (out_tvalid),
        .out_tdata   (out_tdata),
        .out_tkeep   (out_tkeep),
        .out_tlast   (out_tlast),
        .out_tready  (out_tready),
        .oflow       (oflow),
        .pkt_count   (pkt_count),
        .drop_count  (drop_count)
    );

    initial begin
        axis_out_if = 1'b0;
        forever #5 axis_out_if = ~axis_out_if;
    end

    // ========================================
    // Random source and reference model
    // ========================================

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_bit()};
        end
        return val;
    endfunction

    // Free space check against words still held in memory
    function automatic bit predict_kept(input int len, input int backlog);
        int in_mem;
        in_mem = backlog - pipe_words - prefetch_words;
        if (in_mem < 0) begin
            in_mem = 0;
        end
        return (in_mem + len) <= fifo_depth;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_data(input string name, input logic [data_bits-1:0] exp,
                              input logic [data_bits-1:0] act);
        if (act !== exp) begin
            err_value++;
            $display("** Error %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_keep(input string name, input logic [data_bytes-1:0] exp,
                              input logic [data_bytes-1:0] act);
        if (act !== exp) begin
            err_value++;
            $display("** Error %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_count(input string name, input logic [cnt_bits-1:0] exp,
                               input logic [cnt_bits-1:0] act);
        if (act !== exp) begin
            err_value++;
            $display("** Error %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_value++;
            $display("** Error %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    // Advance one clock and change inputs 1 ns after the edge
    task automatic step();
        @(posedge axis_out_if);
        #1;
        if (ready_random) begin
            out_tready = (rand_bits(2) != 0);
        end
    endtask

    task automatic send_packet(input int len, input bit gaps);
        bit kept;
        kept = predict_kept(len, kept_words - rcv_words);
        if (kept) begin
            kept_words += len;
            exp_pkts++;
        end else begin
            exp_drops++;
        end
        for (int i = 0; i < len; i++) begin
            if (gaps) begin
                while (rand_bits(3) == 0) step();
            end
            in_tvalid = 1'b1;
            in_tdata  = {rand_bits(32), rand_bits(32)};
            in_tlast  = (i == len - 1);
            in_tkeep  = in_tlast ? (8'(rand_bits(8)) | 8'h01) : '1;
            if (kept) begin
                exp_data.push_back(in_tdata);
                exp_keep.push_back(in_tkeep);
                exp_last.push_back(in_tlast);
            end
            step();
            in_tvalid = 1'b0;
        end
    endtask

    task automatic drain();
        while (rcv_words < kept_words) step();
        repeat (4) step();
    endtask

    initial begin
        int base_pkts;
        int base_oflow;
        arst_n     = 1'b0;
        in_tvalid  = 1'b0;
        in_tdata   = '0;
        in_tkeep   = '0;
        in_tlast   = 1'b0;
        out_tready = 1'b1;
        total_words = 5 + 70 + 6 * 16;
        for (int i = 0; i < num_random; i++) begin
            rand_len[i] = int'(rand_bits(5)) + 1;
            total_words += rand_len[i];
        end
        watchdog_armed = 1'b1;
        repeat (3) @(posedge axis_out_if);
        #1 arst_n = 1'b1;

        // State straight after reset
        check_flag("out_tvalid", 1'b0, out_tvalid);
        check_flag("oflow", 1'b0, oflow);
        check_count("pkt_count", '0, pkt_count);
        check_count("drop_count", '0, drop_count);

        // Single packet without back-pressure
        send_packet(5, 1'b0);
        drain();
        check_count("pkt_count", cnt_bits'(exp_pkts), pkt_count);

        // Random traffic with the backlog kept within the memory size
        ready_random = 1'b1;
        for (int p = 0; p < num_random; p++) begin
            repeat (int'(rand_bits(3))) step();
            while (kept_words - rcv_words + rand_len[p] > fifo_depth) step();
            send_packet(rand_len[p], 1'b1);
        end
        drain();
        ready_random = 1'b0;
        out_tready   = 1'b1;
        check_count("pkt_count", cnt_bits'(exp_pkts), pkt_count);

        // Oversized packet
        base_oflow = oflow_seen;
        send_packet(70, 1'b0);
        repeat (10) step();
        check_count("oflow pulses", cnt_bits'(1), cnt_bits'(oflow_seen - base_oflow));
        check_count("drop_count", cnt_bits'(exp_drops), drop_count);

        // Six packets into a blocked output
        base_oflow = oflow_seen;
        base_pkts  = rcv_pkts;
        out_tready = 1'b0;
        for (int p = 0; p < 6; p++) begin
            send_packet(16, 1'b0);
        end
        repeat (10) step();
        check_count("oflow pulses", cnt_bits'(2), cnt_bits'(oflow_seen - base_oflow));
        check_count("drop_count", cnt_bits'(exp_drops), drop_count);
        out_tready = 1'b1;
        drain();
        repeat (20) step();
        check_count("received packets", cnt_bits'(4), cnt_bits'(rcv_pkts - base_pkts));
        check_count("pkt_count", cnt_bits'(exp_pkts), pkt_count);

        if (exp_data.size() != 0) begin
            err_other++;
            $display("%0d expected words never reached the output", exp_data.size());
        end
        $display("Errors: %0d value, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // ========================================
    // Output monitor
    // ========================================

    // All signals are settled half a cycle away from the edges
    always @(negedge axis_out_if) begin
        if (arst_n) begin
            if (oflow) begin
                oflow_seen++;
            end
            if (in_pkt && out_tready && !out_tvalid) begin
                err_other++;
                $display("out_tvalid dropped inside a packet at %0t", $time);
            end
            if (out_tvalid && out_tready) begin
                if (exp_data.size() == 0) begin
                    err_other++;
                    $display("Output word arrived with no packet expected at %0t", $time);
                end else begin
                    check_data("out_tdata", exp_data.pop_front(), out_tdata);
                    check_keep("out_tkeep", exp_keep.pop_front(), out_tkeep);
                    check_flag("out_tlast", exp_last.pop_front(), out_tlast);
                end
                rcv_words++;
                in_pkt = !out_tlast;
                if (out_tlast) begin
                    rcv_pkts++;
                end
            end
        end
    end

    // Watchdog allows 20 cycles per word sent plus a margin
    initial begin
        wait (watchdog_armed);
        repeat (total_words * 20 + 1000) @(posedge axis_out_if);
        $display("Watchdog timeout, the run did not complete in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* filelist.f */
axis_pkg.sv
pkt_fifo_pkg.sv
axis_full_pipe.sv
axis_pkt_fifo.sv
axis_pkt_counters.sv
axis_pkt_buffer.sv
tb_axis_pkt_buffer.sv

/* Makefile */
TOP := tb_axis_pkt_buffer
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

obj_dir/V$(TOP): filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f filelist.f --top-module axis_pkt_buffer
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
